// ==== common/game_pkg.sv ====
package game_pkg;

    // Game dimensions
    localparam int ENEMY_NUM = 4;
    localparam int COORD_W   = 9;
    localparam int HP_W      = 7;
    localparam int CNT_W     = 10;

    // Enemy box and attack rectangle in pixels
    localparam int ENEMY_W      = 26;
    localparam int ENEMY_H      = 26;
    localparam int ATTACK_SHORT = 16;
    localparam int ATTACK_LONG  = 80;

    // Damage and health values
    localparam logic [HP_W-1:0]  PLAYER_DAMAGE  = 7'd10;
    localparam logic [CNT_W-1:0] ENEMY_DAMAGE   = 10'd10;
    localparam logic [HP_W-1:0]  ENEMY_FULL_HP  = 7'd100;
    localparam logic [CNT_W-1:0] PLAYER_FULL_HP = 10'd200;

    // Facing direction of the player
    typedef enum logic [1:0] {
        DIR_DOWN  = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_t;

    // Screen position, top left corner of an object
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } pos_t;

    // Player attack request
    typedef struct packed {
        logic attack_on;
        dir_t dir;
        pos_t pos;
    } attack_t;

    // Per enemy results handed to the player status
    typedef struct packed {
        logic             alive;
        logic             hit;
        logic [CNT_W-1:0] score;
        logic [CNT_W-1:0] damage;
        logic [CNT_W-1:0] god_damage;
    } enemy_res_t;

endpackage

// ==== enemy_unit/enemy_unit.sv ====
`timescale 1ns/1ps

module enemy_unit #(
    parameter int id = 0
) (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        tick,
    input  game_pkg::attack_t           attack,
    input  game_pkg::pos_t              pos,
    input  logic                        attack_on,
    input  logic                        godmode_on,
    input  logic [game_pkg::CNT_W-1:0]  respawn_unit,
    output game_pkg::enemy_res_t        res
);
    import game_pkg::*;

    logic [HP_W-1:0]  hp;
    logic [CNT_W-1:0] respawn_cnt;
    logic [CNT_W-1:0] respawn_target;
    logic [CNT_W-1:0] score;
    logic [CNT_W-1:0] damage;
    logic [CNT_W-1:0] god_damage;
    logic             hit_now;
    logic             hit_q;
    logic             alive;

    hit_test u_hit_test (
        .attack (attack),
        .enemy  (pos),
        .hit    (hit_now)
    );

    // Odd enemies wait twice as long before coming back
    assign respawn_target = (id % 2 == 1) ? (respawn_unit << 1) : respawn_unit;

    assign alive = (hp != '0);

    // Health, respawn and score
    always_ff @(posedge Clk) begin
        if (reset) begin
            hp          <= '0;
            respawn_cnt <= '0;
            score       <= '0;
            hit_q       <= 1'b0;
        end else begin
            hit_q <= 1'b0;
            if (tick) begin
                if (!alive) begin
                    if (respawn_cnt == respawn_target) begin
                        respawn_cnt <= '0;
                        hp          <= ENEMY_FULL_HP;
                    end else begin
                        respawn_cnt <= respawn_cnt + 1'b1;
                    end
                end else if (attack.attack_on && hit_now) begin
                    hit_q <= 1'b1;
                    // Saturate at zero, the killing blow scores
                    if (hp > PLAYER_DAMAGE) begin
                        hp <= hp - PLAYER_DAMAGE;
                    end else begin
                        hp    <= '0;
                        score <= score + 1'b1;
                    end
                end
            end
        end
    end

    // Damage dealt to the player, kept apart while god mode is on
    always_ff @(posedge Clk) begin
        if (reset) begin
            damage     <= '0;
            god_damage <= '0;
        end else if (tick && attack_on) begin
            if (godmode_on) begin
                god_damage <= god_damage + ENEMY_DAMAGE;
            end else begin
                damage <= damage + ENEMY_DAMAGE;
            end
        end
    end

    assign res = '{
        alive:      alive,
        hit:        hit_q,
        score:      score,
        damage:     damage,
        god_damage: god_damage
    };

    a_hp_max: assert property (
        @(posedge Clk) disable iff (reset) hp <= ENEMY_FULL_HP
    );

    // Kills only ever accumulate
    a_score_mono: assert property (
        @(posedge Clk) disable iff (reset) score >= $past(score)
    );

endmodule

// ==== enemy_unit/hit_test.sv ====
`timescale 1ns/1ps

module hit_test (
    input  game_pkg::attack_t attack,
    input  game_pkg::pos_t    enemy,
    output logic              hit
);
    import game_pkg::*;

    localparam int W = COORD_W + 2;

    // Every coordinate is shifted up by ATTACK_LONG, so the left and up
    // spans start at a non-negative value
    localparam logic [W-1:0] OFS   = W'(ATTACK_LONG);
    localparam logic [W-1:0] SHORT = W'(ATTACK_SHORT);
    localparam logic [W-1:0] LONG  = W'(ATTACK_LONG);

    logic [W-1:0] ax, ay;
    logic [W-1:0] ex_lo, ex_hi, ey_lo, ey_hi;
    logic [W-1:0] ax_lo, ax_hi, ay_lo, ay_hi;

    assign ax    = W'(attack.pos.x) + OFS;
    assign ay    = W'(attack.pos.y) + OFS;
    assign ex_lo = W'(enemy.x) + OFS;
    assign ex_hi = ex_lo + W'(ENEMY_W);
    assign ey_lo = W'(enemy.y) + OFS;
    assign ey_hi = ey_lo + W'(ENEMY_H);

    // Attack rectangle per facing direction
    always_comb begin
        ax_lo = ax;
        ax_hi = ax + SHORT;
        ay_lo = ay;
        ay_hi = ay + LONG;
        case (attack.dir)
            DIR_DOWN: begin
                ay_hi = ay + LONG;
            end
            DIR_UP: begin
                ay_lo = ay - LONG;
                ay_hi = ay;
            end
            DIR_LEFT: begin
                ax_lo = ax - LONG;
                ax_hi = ax;
                ay_hi = ay + SHORT;
            end
            DIR_RIGHT: begin
                ax_hi = ax + LONG;
                ay_hi = ay + SHORT;
            end
        endcase
    end

    // Closed ranges overlap on both axes
    assign hit = (ax_lo <= ex_hi) && (ex_lo <= ax_hi) &&
                 (ay_lo <= ey_hi) && (ey_lo <= ay_hi);

endmodule

// ==== game_core.f ====
common/game_pkg.sv
rtl/frame_tick.sv
enemy_unit/hit_test.sv
enemy_unit/enemy_unit.sv
rtl/player_status.sv
rtl/game_core.sv
verification/game_core_tb.sv

// ==== rtl/frame_tick.sv ====
`timescale 1ns/1ps

module frame_tick (
    input  logic Clk,
    input  logic reset,
    input  logic frame_clk,
    output logic tick
);

    logic sync_1;
    logic sync_2;
    logic sync_d;

    // Two flop synchronizer, then rising edge detect
    always_ff @(posedge Clk) begin
        if (reset) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            sync_d <= 1'b0;
            tick   <= 1'b0;
        end else begin
            sync_1 <= frame_clk;
            sync_2 <= sync_1;
            sync_d <= sync_2;
            tick   <= sync_2 & ~sync_d;
        end
    end

    // One pulse per frame, never two in a row
    a_tick_single: assert property (
        @(posedge Clk) disable iff (reset) tick |=> !tick
    );

endmodule

// ==== rtl/game_core.sv ====
`timescale 1ns/1ps

module game_core (
    input  logic                          Clk,
    input  logic                          reset,
    input  logic                          frame_clk,
    input  game_pkg::attack_t             attack,
    input  game_pkg::pos_t                enemy_pos [game_pkg::ENEMY_NUM],
    input  logic [game_pkg::ENEMY_NUM-1:0] enemy_attack_on,
    input  logic                          godmode_on,
    input  logic [game_pkg::CNT_W-1:0]    respawn_unit,
    output logic [game_pkg::ENEMY_NUM-1:0] enemy_alive,
    output logic [game_pkg::ENEMY_NUM-1:0] enemy_hit,
    output logic [game_pkg::CNT_W-1:0]    total_score,
    output logic [game_pkg::CNT_W-1:0]    player_hp,
    output logic [game_pkg::CNT_W-1:0]    god_damage,
    output logic                          game_over
);
    import game_pkg::*;

    logic       tick;
    enemy_res_t res [ENEMY_NUM];

    // One pulse per frame clock rise
    frame_tick u_frame_tick (
        .Clk       (Clk),
        .reset     (reset),
        .frame_clk (frame_clk),
        .tick      (tick)
    );

    for (genvar i = 0; i < ENEMY_NUM; i++) begin : g_enemy
        enemy_unit #(
            .id (i)
        ) u_enemy_unit (
            .Clk          (Clk),
            .reset        (reset),
            .tick         (tick),
            .attack       (attack),
            .pos          (enemy_pos[i]),
            .attack_on    (enemy_attack_on[i]),
            .godmode_on   (godmode_on),
            .respawn_unit (respawn_unit),
            .res          (res[i])
        );

        assign enemy_alive[i] = res[i].alive;
        assign enemy_hit[i]   = res[i].hit;
    end

    player_status u_player_status (
        .Clk         (Clk),
        .reset       (reset),
        .res         (res),
        .player_hp   (player_hp),
        .total_score (total_score),
        .god_damage  (god_damage),
        .game_over   (game_over)
    );

endmodule

// ==== rtl/player_status.sv ====
`timescale 1ns/1ps

module player_status (
    input  logic                       Clk,
    input  logic                       reset,
    input  game_pkg::enemy_res_t       res [game_pkg::ENEMY_NUM],
    output logic [game_pkg::CNT_W-1:0] player_hp,
    output logic [game_pkg::CNT_W-1:0] total_score,
    output logic [game_pkg::CNT_W-1:0] god_damage,
    output logic                       game_over
);
    import game_pkg::*;

    // Two extra bits so four tallies cannot overflow the damage sum
    localparam int SUM_W = CNT_W + 2;

    logic [SUM_W-1:0] damage_sum;
    logic [CNT_W-1:0] score_sum;
    logic [CNT_W-1:0] god_sum;
    logic [CNT_W-1:0] hp_next;

    always_comb begin
        damage_sum = '0;
        score_sum  = '0;
        god_sum    = '0;
        for (int i = 0; i < ENEMY_NUM; i++) begin
            damage_sum = damage_sum + SUM_W'(res[i].damage);
            score_sum  = score_sum + res[i].score;
            god_sum    = god_sum + res[i].god_damage;
        end
    end

    // Player health saturates at zero
    always_comb begin
        if (damage_sum >= SUM_W'(PLAYER_FULL_HP)) begin
            hp_next = '0;
        end else begin
            hp_next = PLAYER_FULL_HP - damage_sum[CNT_W-1:0];
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            player_hp   <= PLAYER_FULL_HP;
            total_score <= '0;
            god_damage  <= '0;
            game_over   <= 1'b0;
        end else begin
            player_hp   <= hp_next;
            total_score <= score_sum;
            god_damage  <= god_sum;
            // Sticky until reset
            if (hp_next == '0) begin
                game_over <= 1'b1;
            end
        end
    end

    a_game_over_sticky: assert property (
        @(posedge Clk) disable iff (reset) game_over |=> game_over
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the game_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module game_core_tb \
    -f game_core.f \
    -o game_core_sim

./obj_dir/game_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// ==== verification/game_core_tb.sv ====
`timescale 1ns/1ps

module game_core_tb;
    import game_pkg::*;

    // Layout of one frame line in the pattern file
    localparam int FIELDS     = 22;
    localparam int MAX_FRAMES = 64;
    localparam int END_TEST   = 'hff;
    localparam int F_TEST     = 0;
    localparam int F_ATK      = 1;
    localparam int F_DIR      = 2;
    localparam int F_AX       = 3;
    localparam int F_AY       = 4;
    localparam int F_EPOS     = 5;
    localparam int F_EATK     = 13;
    localparam int F_GOD      = 14;
    localparam int F_RESP     = 15;
    localparam int F_ALIVE    = 16;
    localparam int F_HIT      = 17;
    localparam int F_SCORE    = 18;
    localparam int F_HP       = 19;
    localparam int F_GODDMG   = 20;
    localparam int F_OVER     = 21;

    logic                 Clk;
    logic                 reset;
    logic                 frame_clk;
    attack_t              attack;
    pos_t                 enemy_pos [ENEMY_NUM];
    logic [ENEMY_NUM-1:0] enemy_attack_on;
    logic                 godmode_on;
    logic [CNT_W-1:0]     respawn_unit;
    logic [ENEMY_NUM-1:0] enemy_alive;
    logic [ENEMY_NUM-1:0] enemy_hit;
    logic [CNT_W-1:0]     total_score;
    logic [CNT_W-1:0]     player_hp;
    logic [CNT_W-1:0]     god_damage;
    logic                 game_over;

    logic [15:0]          pattern_mem [FIELDS*MAX_FRAMES];
    logic [ENEMY_NUM-1:0] hit_seen;
    int                   test_errors;
    int                   total_errors;
    int                   tests_passed;
    int                   tests_failed;
    int                   frame;
    int                   current_test;
    logic                 done;

    game_core UUT (
        .Clk             (Clk),
        .reset           (reset),
        .frame_clk       (frame_clk),
        .attack          (attack),
        .enemy_pos       (enemy_pos),
        .enemy_attack_on (enemy_attack_on),
        .godmode_on      (godmode_on),
        .respawn_unit    (respawn_unit),
        .enemy_alive     (enemy_alive),
        .enemy_hit       (enemy_hit),
        .total_score     (total_score),
        .player_hp       (player_hp),
        .god_damage      (god_damage),
        .game_over       (game_over)
    );

    always #2 Clk = ~Clk;

    function automatic logic [15:0] read_field(input int line, input int idx);
        return pattern_mem[line*FIELDS + idx];
    endfunction

    task automatic apply_inputs(input int line);
        attack.attack_on = 1'(read_field(line, F_ATK));
        attack.dir       = dir_t'(2'(read_field(line, F_DIR)));
        attack.pos.x     = COORD_W'(read_field(line, F_AX));
        attack.pos.y     = COORD_W'(read_field(line, F_AY));
        for (int i = 0; i < ENEMY_NUM; i++) begin
            enemy_pos[i].x = COORD_W'(read_field(line, F_EPOS + 2*i));
            enemy_pos[i].y = COORD_W'(read_field(line, F_EPOS + 2*i + 1));
        end
        enemy_attack_on = ENEMY_NUM'(read_field(line, F_EATK));
        godmode_on      = 1'(read_field(line, F_GOD));
        respawn_unit    = CNT_W'(read_field(line, F_RESP));
    endtask

    // One frame clock period of 16 cycles, hit pulses collected on the way
    task automatic run_frame();
        hit_seen  = '0;
        frame_clk = 1'b1;
        repeat (8) begin
            @(posedge Clk);
            #1;
            hit_seen = hit_seen | enemy_hit;
        end
        frame_clk = 1'b0;
        repeat (8) begin
            @(posedge Clk);
            #1;
            hit_seen = hit_seen | enemy_hit;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("mismatch at %0t ns: %s expected %0h, actual %0h",
                 $time, name, expected, actual);
        test_errors++;
    endtask

    task automatic check_outputs(input int line);
        if (16'(enemy_alive) !== read_field(line, F_ALIVE))
            report_mismatch("enemy_alive", read_field(line, F_ALIVE), 16'(enemy_alive));
        if (16'(hit_seen) !== read_field(line, F_HIT))
            report_mismatch("enemy_hit", read_field(line, F_HIT), 16'(hit_seen));
        if (16'(total_score) !== read_field(line, F_SCORE))
            report_mismatch("total_score", read_field(line, F_SCORE), 16'(total_score));
        if (16'(player_hp) !== read_field(line, F_HP))
            report_mismatch("player_hp", read_field(line, F_HP), 16'(player_hp));
        if (16'(god_damage) !== read_field(line, F_GODDMG))
            report_mismatch("god_damage", read_field(line, F_GODDMG), 16'(god_damage));
        if (16'(game_over) !== read_field(line, F_OVER))
            report_mismatch("game_over", read_field(line, F_OVER), 16'(game_over));
    endtask

    task automatic close_test(input int test_num);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed", test_num);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d mismatches", test_num, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        Clk             = 1'b0;
        reset           = 1'b1;
        frame_clk       = 1'b0;
        attack          = '0;
        enemy_attack_on = '0;
        godmode_on      = 1'b0;
        respawn_unit    = '0;
        for (int i = 0; i < ENEMY_NUM; i++) begin
            enemy_pos[i] = '0;
        end
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        done         = 1'b0;
        frame        = 0;
        $readmemh("verification/game_patterns.txt", pattern_mem);

        repeat (4) @(posedge Clk);
        #1;
        reset = 1'b0;

        // Frames run until the end marker, bounded by the memory depth
        current_test = int'(read_field(0, F_TEST));
        while (!done && frame < MAX_FRAMES) begin
            if (int'(read_field(frame, F_TEST)) == END_TEST) begin
                done = 1'b1;
            end else begin
                if (int'(read_field(frame, F_TEST)) != current_test) begin
                    close_test(current_test);
                    current_test = int'(read_field(frame, F_TEST));
                end
                apply_inputs(frame);
                run_frame();
                check_outputs(frame);
                frame++;
            end
        end

        if (!done || frame == 0) begin
            $display("end marker of the pattern file not found, or no frames in it");
            $display("TEST FAIL");
        end else begin
            close_test(current_test);
            $display("%0d tests passed, %0d tests failed, %0d mismatches in %0d frames",
                     tests_passed, tests_failed, total_errors, frame);
            if (tests_failed == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

endmodule

// ==== verification/game_patterns.txt ====
// test atk dir ax ay e0x e0y e1x e1y e2x e2y e3x e3y eatk god resp
//   then expected alive hit score hp god_damage game_over, ff ends the file
// Respawn
01 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 0 0 0 c8 00 0
01 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 0 0 0 c8 00 0
01 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 5 0 0 c8 00 0
01 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 5 0 0 c8 00 0
01 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 0 0 c8 00 0
// Directional hits, then ten hits down on enemy 0
02 1 2 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 2 0 c8 00 0
02 1 1 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 4 0 c8 00 0
02 1 3 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 8 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 f 1 0 c8 00 0
02 1 0 c8 c8 c8 fa c8 82 82 cd fa cd 0 0 2 e 1 1 c8 00 0
// Damage to the player while enemy 0 respawns
03 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 3 0 2 e 0 1 b4 00 0
03 0 0 c8 c8 c8 fa c8 82 82 cd fa cd f 0 2 e 0 1 8c 00 0
03 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 1 0 2 f 0 1 82 00 0
// God mode
04 0 0 c8 c8 c8 fa c8 82 82 cd fa cd f 1 2 f 0 1 82 28 0
04 0 0 c8 c8 c8 fa c8 82 82 cd fa cd f 1 2 f 0 1 82 50 0
// Game over
05 0 0 c8 c8 c8 fa c8 82 82 cd fa cd f 0 2 f 0 1 5a 50 0
05 0 0 c8 c8 c8 fa c8 82 82 cd fa cd f 0 2 f 0 1 32 50 0
05 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 3 0 2 f 0 1 1e 50 0
05 0 0 c8 c8 c8 fa c8 82 82 cd fa cd 7 0 2 f 0 1 00 50 1
05 0 0 c8 c8 c8 fa c8 82 82 cd fa cd f 0 2 f 0 1 00 50 1
ff 0 0 00 00 00 00 00 00 00 00 00 00 0 0 0 0 0 0 00 00 0
